//--- Bender.yml
package:
  name: lsu

sources:
  - files:
      - verilog/lsu_pkg.sv
      - verilog/lsu_request_gen.sv
      - verilog/lsu_txn_ctrl.sv
      - verilog/lsu_rdata_align.sv
      - verilog/lsu_top.sv
  - target: test
    files:
      - test/lsu_mem_model.sv
      - test/lsu_tb.sv

//--- sources.f
verilog/lsu_pkg.sv
verilog/lsu_request_gen.sv
verilog/lsu_txn_ctrl.sv
verilog/lsu_rdata_align.sv
verilog/lsu_top.sv
test/lsu_mem_model.sv
test/lsu_tb.sv

//--- test/lsu_mem_model.sv
////////////////////////////////////////////////////////////
// Data bus memory model
// 256 byte memory with random grant delay, in-order
// responses and an error region at the top
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_mem_model (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  output logic                   gnt_o,
  input  lsu_pkg::lsu_bus_req_t  req_data_i,
  output logic                   rvalid_o,
  output lsu_pkg::lsu_bus_resp_t resp_o
);

  import lsu_pkg::*;

  logic [7:0]    mem [256];
  logic [1:0]    gnt_wait_q;
  int unsigned   cycle_q;
  // Pending responses with the cycle they become due
  lsu_bus_resp_t resp_q [$];
  int unsigned   due_q [$];
  logic [7:0]    base;
  lsu_bus_resp_t resp;

  // Every address bit reaches the byte value
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i * 37 + 11);
    end
  end

  assign gnt_o = req_i && (gnt_wait_q == 2'd0);
  assign base  = {req_data_i.addr[7:2], 2'b00};

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_wait_q <= 2'd0;
      cycle_q    <= 0;
      rvalid_o   <= 1'b0;
      resp_o     <= '0;
      resp_q.delete();
      due_q.delete();
    end else begin
      cycle_q <= cycle_q + 1;
      if (gnt_o) begin
        gnt_wait_q <= 2'($urandom_range(2, 0));
        resp.err = (req_data_i.addr >= LSU_ERR_ADDR_LO);
        if (req_data_i.we && !resp.err) begin
          for (int b = 0; b < 4; b++) begin
            if (req_data_i.be[b]) mem[8'(base + b)] = req_data_i.wdata[8*b +: 8];
          end
        end
        resp.rdata = {mem[8'(base + 3)], mem[8'(base + 2)], mem[8'(base + 1)], mem[base]};
        // Zero extra delay answers in the cycle right after the grant
        resp_q.push_back(resp);
        due_q.push_back(cycle_q + $urandom_range(2, 0));
      end else if (req_i && gnt_wait_q != 2'd0) begin
        gnt_wait_q <= gnt_wait_q - 2'd1;
      end
      // Oldest response first, one per cycle
      rvalid_o <= 1'b0;
      if (due_q.size() != 0 && due_q[0] <= cycle_q) begin
        rvalid_o <= 1'b1;
        resp_o   <= resp_q.pop_front();
        void'(due_q.pop_front());
      end
    end
  end

endmodule

//--- test/lsu_tb.sv
////////////////////////////////////////////////////////////
// Load/store unit testbench
// Drives EX requests against a bus memory model and checks
// bus phases and WB responses with concurrent assertions
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_tb;

  import lsu_pkg::*;

  logic          clk;
  logic          rst_n;
  logic          ex_valid_i;
  lsu_ex_req_t   ex_req_i;
  logic          ex_ready_o;
  logic          bus_req_o;
  logic          bus_gnt_i;
  lsu_bus_req_t  bus_req_data_o;
  logic          bus_rvalid_i;
  lsu_bus_resp_t bus_resp_i;
  logic          wb_valid_o;
  lsu_data_t     wb_rdata_o;
  logic          wb_err_o;
  logic          wb_last_o;
  logic          busy_o;
  logic          interruptible_o;

  // Reference memory, updated on each accepted store
  logic [7:0]  ref_mem [256];
  // Expected data per access and {err, last} per response
  lsu_data_t   acc_exp_a [256];
  logic [1:0]  rsp_exp_a [256];
  logic [7:0]  acc_push;
  logic [7:0]  acc_pop;
  logic [7:0]  rsp_push;
  logic [7:0]  rsp_pop;
  lsu_data_t   acc_head;
  logic [1:0]  rsp_head;
  int          gnt_seen;
  int          exp_phases;
  int          n_grants;
  int          n_resps;
  lsu_addr_t   ex_addr;
  lsu_addr_t   exp_addr;
  int          n_issued;
  int          n_tests;
  int          err_cnt;
  int          test_err0;
  int          cycles;
  string       test_name;
  logic        check_idle;

  lsu_top i_lsu_top (.*);

  lsu_mem_model i_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (bus_req_o),
    .gnt_o      (bus_gnt_i),
    .req_data_i (bus_req_data_o),
    .rvalid_o   (bus_rvalid_i),
    .resp_o     (bus_resp_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = 8'(i * 37 + 11);
    end
  end

  ////////////////////////////////////////////////////////////
  // Expected values from the access rules
  ////////////////////////////////////////////////////////////

  function automatic int byte_count(lsu_size_e size);
    case (size)
      LSU_BYTE: return 1;
      LSU_HALF: return 2;
      default:  return 4;
    endcase
  endfunction

  // Crossing a word boundary takes two bus phases
  function automatic int phase_count(lsu_size_e size, logic [1:0] off);
    return (off + byte_count(size) > 4) ? 2 : 1;
  endfunction

  function automatic lsu_data_t load_value(lsu_addr_t addr, lsu_size_e size, logic sext);
    lsu_data_t v;
    int        n;
    n = byte_count(size);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = ref_mem[8'(addr + i)];
    end
    // Sign from the top loaded bit
    if (sext && v[8*n-1]) begin
      for (int i = n; i < 4; i++) begin
        v[8*i +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  assign ex_addr    = ex_req_i.operand_a + ex_req_i.operand_b;
  assign exp_phases = phase_count(ex_req_i.size, ex_addr[1:0]);
  // Second phase goes to the start of the following word
  assign exp_addr   = (gnt_seen == 0) ? ex_addr : {ex_addr[31:2], 2'b00} + 32'd4;
  assign acc_head   = acc_exp_a[acc_pop];
  assign rsp_head   = rsp_exp_a[rsp_pop];

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      {acc_push, acc_pop, rsp_push, rsp_pop} <= '0;
      gnt_seen <= 0;
      n_grants <= 0;
      n_resps  <= 0;
    end else begin
      if (bus_req_o && bus_gnt_i) begin
        rsp_exp_a[rsp_push] <= {exp_addr >= LSU_ERR_ADDR_LO, gnt_seen == exp_phases - 1};
        rsp_push <= rsp_push + 8'd1;
        n_grants <= n_grants + 1;
        gnt_seen <= (ex_valid_i && ex_ready_o) ? 0 : gnt_seen + 1;
      end
      if (wb_valid_o) begin
        rsp_pop <= rsp_pop + 8'd1;
        n_resps <= n_resps + 1;
      end
      if (wb_last_o) acc_pop <= acc_pop + 8'd1;
      if (ex_valid_i && ex_ready_o) begin
        acc_exp_a[acc_push] <= ex_req_i.we ? '0 :
                               load_value(ex_addr, ex_req_i.size, ex_req_i.sext);
        acc_push <= acc_push + 8'd1;
        if (ex_req_i.we) begin
          for (int i = 0; i < byte_count(ex_req_i.size); i++) begin
            ref_mem[8'(ex_addr + i)] = ex_req_i.wdata[8*i +: 8];
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_idle : assert property (@(posedge clk) disable iff (!rst_n)
    check_idle |-> {bus_req_o, wb_valid_o, busy_o, interruptible_o} == 4'b0001)
  else begin
    err_cnt++;
    $display("Fail %s expected %b actual %b", test_name, 4'b0001,
             $sampled({bus_req_o, wb_valid_o, busy_o, interruptible_o}));
  end

  a_addr : assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_o && bus_gnt_i |-> bus_req_data_o.addr == exp_addr)
  else begin
    err_cnt++;
    $display("Fail %s expected %h actual %h", test_name, $sampled(exp_addr),
             $sampled(bus_req_data_o.addr));
  end

  // EX completes with the last expected grant
  a_phases : assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i && ex_ready_o |-> bus_gnt_i && gnt_seen == exp_phases - 1)
  else begin
    err_cnt++;
    $display("Fail %s expected %0d actual %0d", test_name, $sampled(exp_phases),
             $sampled(gnt_seen) + 1);
  end

  a_resp : assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid_o |-> {wb_err_o, wb_last_o} == rsp_exp_a[rsp_pop])
  else begin
    err_cnt++;
    $display("Fail %s expected %b actual %b", test_name, $sampled(rsp_head),
             $sampled({wb_err_o, wb_last_o}));
  end

  a_data : assert property (@(posedge clk) disable iff (!rst_n)
    wb_last_o |-> wb_rdata_o == acc_exp_a[acc_pop])
  else begin
    err_cnt++;
    $display("Fail %s expected %h actual %h", test_name, $sampled(acc_head),
             $sampled(wb_rdata_o));
  end

  a_depth : assert property (@(posedge clk) disable iff (!rst_n)
    n_grants - n_resps <= LSU_DEPTH)
  else begin
    err_cnt++;
    $display("Outstanding transactions exceed the limit in %s", test_name);
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic issue_access(input logic we, input lsu_size_e size, input logic sext,
                              input lsu_addr_t a, input lsu_addr_t b, input lsu_data_t wdata);
    @(negedge clk);
    ex_valid_i = 1'b1;
    ex_req_i   = '{operand_a: a, operand_b: b, wdata: wdata, we: we, size: size, sext: sext};
    n_issued++;
    do @(posedge clk); while (!ex_ready_o);
  endtask

  task automatic drain();
    @(negedge clk);
    ex_valid_i = 1'b0;
    for (int i = 0; i < 200 && (busy_o || n_grants != n_resps); i++) begin
      @(negedge clk);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    drain();
    n_tests++;
    $display("%-18s done, %0d errors", test_name, err_cnt - test_err0);
  endtask

  initial begin
    void'($urandom(32'h7a7b));
    {n_issued, n_tests, err_cnt, test_err0} = '0;
    rst_n      = 1'b0;
    ex_valid_i = 1'b0;
    ex_req_i   = '0;
    check_idle = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    begin_test("reset_idle");
    check_idle = 1'b1;
    repeat (10) @(negedge clk);
    check_idle = 1'b0;
    end_test();

    begin_test("aligned_access");
    issue_access(1'b1, LSU_WORD, 1'b0, 32'h0, 32'h0, 32'h80ff_7f01);
    for (int i = 1; i < 8; i++) begin
      issue_access(1'b1, LSU_WORD, 1'b0, 32'h8, 4 * i - 8, $urandom);
    end
    for (int i = 0; i < 8; i++) begin
      issue_access(1'b0, LSU_WORD, 1'b0, 4 * i, 32'h0, '0);
      for (int h = 0; h < 2; h++) begin
        issue_access(1'b0, LSU_HALF, i[0], 4 * i, 2 * h, '0);
      end
      for (int k = 0; k < 4; k++) begin
        issue_access(1'b0, LSU_BYTE, k[0], 4 * i, k, '0);
      end
    end
    end_test();

    begin_test("misaligned_load");
    for (int off = 1; off < 4; off++) begin
      issue_access(1'b0, LSU_WORD, 1'b0, 32'h20, off, '0);
    end
    issue_access(1'b0, LSU_HALF, 1'b1, 32'h20, 32'h3, '0);
    issue_access(1'b0, LSU_HALF, 1'b0, 32'h28, 32'h3, '0);
    issue_access(1'b0, LSU_WORD, 1'b1, 32'h2e, 32'h1, '0);
    end_test();

    begin_test("misaligned_store");
    issue_access(1'b1, LSU_WORD, 1'b0, 32'h40, 32'h1, $urandom);
    issue_access(1'b1, LSU_WORD, 1'b0, 32'h48, 32'h2, $urandom);
    issue_access(1'b1, LSU_WORD, 1'b0, 32'h54, 32'h3, $urandom);
    issue_access(1'b1, LSU_HALF, 1'b0, 32'h60, 32'h3, $urandom);
    for (int i = 0; i < 10; i++) begin
      issue_access(1'b0, LSU_WORD, 1'b0, 32'h40, 4 * i, '0);
    end
    end_test();

    begin_test("bus_error");
    issue_access(1'b0, LSU_WORD, 1'b0, LSU_ERR_ADDR_LO, 32'h0, '0);
    issue_access(1'b0, LSU_BYTE, 1'b1, 32'hd0, 32'h5, '0);
    issue_access(1'b0, LSU_WORD, 1'b0, 32'hfc, 32'h0, '0);
    issue_access(1'b0, LSU_WORD, 1'b0, 32'hbc, 32'h0, '0);
    issue_access(1'b0, LSU_BYTE, 1'b0, 32'hbc, 32'h3, '0);
    end_test();

    begin_test("back_to_back");
    for (int i = 0; i < 12; i++) begin
      issue_access(1'b0, LSU_WORD, 1'b0, 4 * $urandom_range(47, 0), 32'h0, '0);
    end
    end_test();

    a_balanced : assert (n_grants == n_resps && !busy_o)
    else begin
      err_cnt++;
      $display("Bus left unbalanced with %0d grants and %0d responses, busy %b",
               n_grants, n_resps, busy_o);
    end

    $display("Tests run: %0d, errors: %0d", n_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Run limit grows with each issued access
  initial cycles = 0;
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > 40 * n_issued + 100) begin
      $display("Timeout after %0d cycles in %s, the LSU stopped making progress",
               cycles, test_name);
      $display("Finished with errors");
      $finish;
    end
  end

endmodule

//--- verilog/lsu_pkg.sv
////////////////////////////////////////////////////////////
// Load/store unit shared definitions
// Widths, access size encoding and the structs that carry
// requests and responses between EX, the bus and WB
////////////////////////////////////////////////////////////

package lsu_pkg;

  // Bus and datapath widths
  localparam int LSU_ADDR_W = 32;
  localparam int LSU_DATA_W = 32;
  localparam int LSU_BE_W   = 4;

  // Maximum outstanding bus transactions
  localparam int LSU_DEPTH = 2;

  // Testbench memory answers with an error from here upwards
  localparam logic [LSU_ADDR_W-1:0] LSU_ERR_ADDR_LO = 32'h0000_00c0;

  typedef logic [LSU_ADDR_W-1:0] lsu_addr_t;
  typedef logic [LSU_DATA_W-1:0] lsu_data_t;
  typedef logic [LSU_BE_W-1:0]   lsu_be_t;
  typedef logic [1:0]            lsu_offset_t;
  typedef logic [1:0]            lsu_cnt_t;

  // Access size, same encoding as funct3[1:0]
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////////////////////////
  // Request and response payloads
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    lsu_addr_t operand_a;
    lsu_addr_t operand_b;
    lsu_data_t wdata;
    logic      we;
    lsu_size_e size;
    logic      sext;
  } lsu_ex_req_t;

  typedef struct packed {
    lsu_addr_t addr;
    logic      we;
    lsu_be_t   be;
    lsu_data_t wdata;
  } lsu_bus_req_t;

  typedef struct packed {
    lsu_data_t rdata;
    logic      err;
  } lsu_bus_resp_t;

  // Per transaction info kept until its response
  typedef struct packed {
    lsu_size_e   size;
    logic        sext;
    logic        we;
    lsu_offset_t offset;
    logic        split_first;
    logic        last;
  } lsu_txn_info_t;

endpackage

//--- verilog/lsu_rdata_align.sv
////////////////////////////////////////////////////////////
// Load/store read data alignment
// Joins split halves, shifts the addressed bytes down and
// zero or sign extends them for the WB stage
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_rdata_align (
  input  logic                   clk,
  input  logic                   rst_n,
  input  lsu_pkg::lsu_txn_info_t head_info_i,
  input  logic                   bus_rvalid_i,
  input  lsu_pkg::lsu_bus_resp_t bus_resp_i,
  output logic                   wb_valid_o,
  output lsu_pkg::lsu_data_t     wb_rdata_o,
  output logic                   wb_err_o,
  output logic                   wb_last_o
);

  import lsu_pkg::*;

  // Raw word of the first half of a split load
  lsu_data_t               first_q;
  logic                    is_split;
  logic [2*LSU_DATA_W-1:0] rdata_full;
  logic [2*LSU_DATA_W-1:0] rdata_shift;
  lsu_data_t               rdata_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q <= '0;
    end else if (bus_rvalid_i && head_info_i.split_first && !head_info_i.we) begin
      first_q <= bus_resp_i.rdata;
    end
  end

  // Word not word aligned, or halfword at offset 3
  assign is_split = ((head_info_i.size == LSU_WORD) && (head_info_i.offset != 2'b00)) ||
                    ((head_info_i.size == LSU_HALF) && (head_info_i.offset == 2'b11));

  // Doubling the word lets the shift wrap high bytes into place
  assign rdata_full = is_split ? {bus_resp_i.rdata, first_q}
                               : {bus_resp_i.rdata, bus_resp_i.rdata};

  assign rdata_shift = rdata_full >> {head_info_i.offset, 3'b000};

  ////////////////////////////////////////////////////////////
  // Extension
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (head_info_i.size)
      LSU_BYTE: rdata_ext = {{24{head_info_i.sext && rdata_shift[7]}}, rdata_shift[7:0]};
      LSU_HALF: rdata_ext = {{16{head_info_i.sext && rdata_shift[15]}}, rdata_shift[15:0]};
      default:  rdata_ext = rdata_shift[LSU_DATA_W-1:0];
    endcase
  end

  // Every response goes to WB, the final one carries the data
  assign wb_valid_o = bus_rvalid_i;
  assign wb_last_o  = bus_rvalid_i && head_info_i.last;
  assign wb_err_o   = bus_rvalid_i && bus_resp_i.err;

  // Stores and first halves return zero
  always_comb begin
    if (head_info_i.we || !head_info_i.last) begin
      wb_rdata_o = '0;
    end else begin
      wb_rdata_o = rdata_ext;
    end
  end

endmodule

//--- verilog/lsu_request_gen.sv
////////////////////////////////////////////////////////////
// Load/store request generation
// Forms the address, detects misaligned splits, builds the
// byte enables and rotated write data for each bus phase
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_request_gen (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ex_valid_i,
  input  lsu_pkg::lsu_ex_req_t ex_req_i,
  input  logic                 ex_update_i,
  output lsu_pkg::lsu_bus_req_t  bus_req_data_o,
  output logic                   split_o,
  output logic                   first_op_o,
  output lsu_pkg::lsu_txn_info_t txn_info_o
);

  import lsu_pkg::*;

  lsu_addr_t   addr;
  lsu_offset_t offset;
  lsu_be_t     size_mask;
  logic [2*LSU_BE_W-1:0]   be_wide;
  logic [2*LSU_DATA_W-1:0] wdata_rot;
  // Second address phase of a split access in progress
  logic        split_q;

  // Effective address
  assign addr   = ex_req_i.operand_a + ex_req_i.operand_b;
  assign offset = addr[1:0];

  // Split needed when the access crosses a word boundary
  always_comb begin
    split_o = 1'b0;
    if (ex_valid_i && !split_q) begin
      case (ex_req_i.size)
        LSU_WORD: split_o = (offset != 2'b00);
        LSU_HALF: split_o = (offset == 2'b11);
        default:  split_o = 1'b0;
      endcase
    end
  end

  assign first_op_o = !split_q;

  // Cleared between instructions so a new access starts in phase one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!ex_valid_i) begin
      split_q <= 1'b0;
    end else if (ex_update_i) begin
      split_q <= split_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // Byte enables and write data
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (ex_req_i.size)
      LSU_BYTE: size_mask = 4'b0001;
      LSU_HALF: size_mask = 4'b0011;
      default:  size_mask = 4'b1111;
    endcase
  end

  // Lower nibble covers phase one, upper nibble spills into the next word
  assign be_wide = {4'b0000, size_mask} << offset;

  // Rotate left by offset bytes, both phases use the same lanes
  assign wdata_rot = {ex_req_i.wdata, ex_req_i.wdata} << {offset, 3'b000};

  always_comb begin
    bus_req_data_o.we    = ex_req_i.we;
    bus_req_data_o.wdata = wdata_rot[2*LSU_DATA_W-1:LSU_DATA_W];
    if (split_q) begin
      // Next word, word aligned
      bus_req_data_o.addr = {addr[LSU_ADDR_W-1:2] + 30'd1, 2'b00};
      bus_req_data_o.be   = be_wide[2*LSU_BE_W-1:LSU_BE_W];
    end else begin
      bus_req_data_o.addr = addr;
      bus_req_data_o.be   = be_wide[LSU_BE_W-1:0];
    end
  end

  // Info travelling with this phase to WB
  always_comb begin
    txn_info_o.size        = ex_req_i.size;
    txn_info_o.sext        = ex_req_i.sext;
    txn_info_o.we          = ex_req_i.we;
    txn_info_o.offset      = offset;
    txn_info_o.split_first = split_o;
    txn_info_o.last        = !split_o;
  end

  // EX holds its request through both phases of a split
  a_req_stable_in_phase2 : assert property (
    @(posedge clk) disable iff (!rst_n) (ex_valid_i && split_q) |-> $stable(ex_req_i)
  );

endmodule

//--- verilog/lsu_top.sv
////////////////////////////////////////////////////////////
// Load/store unit top level
// Connects request generation, transaction control and
// read data alignment between EX, the data bus and WB
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // EX side
  input  logic                   ex_valid_i,
  input  lsu_pkg::lsu_ex_req_t   ex_req_i,
  output logic                   ex_ready_o,
  // Bus address phase
  output logic                   bus_req_o,
  input  logic                   bus_gnt_i,
  output lsu_pkg::lsu_bus_req_t  bus_req_data_o,
  // Bus response phase
  input  logic                   bus_rvalid_i,
  input  lsu_pkg::lsu_bus_resp_t bus_resp_i,
  // WB side
  output logic                   wb_valid_o,
  output lsu_pkg::lsu_data_t     wb_rdata_o,
  output logic                   wb_err_o,
  output logic                   wb_last_o,
  // Status
  output logic                   busy_o,
  output logic                   interruptible_o
);

  import lsu_pkg::*;

  logic          split;
  logic          first_op;
  logic          ex_update;
  lsu_txn_info_t txn_info;
  lsu_txn_info_t head_info;

  lsu_request_gen i_request_gen (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_valid_i     (ex_valid_i),
    .ex_req_i       (ex_req_i),
    .ex_update_i    (ex_update),
    .bus_req_data_o (bus_req_data_o),
    .split_o        (split),
    .first_op_o     (first_op),
    .txn_info_o     (txn_info)
  );

  lsu_txn_ctrl i_txn_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid_i),
    .split_i         (split),
    .txn_info_i      (txn_info),
    .bus_gnt_i       (bus_gnt_i),
    .bus_rvalid_i    (bus_rvalid_i),
    .bus_req_o       (bus_req_o),
    .ex_update_o     (ex_update),
    .ex_ready_o      (ex_ready_o),
    .head_info_o     (head_info),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o)
  );

  lsu_rdata_align i_rdata_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .head_info_i  (head_info),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_resp_i   (bus_resp_i),
    .wb_valid_o   (wb_valid_o),
    .wb_rdata_o   (wb_rdata_o),
    .wb_err_o     (wb_err_o),
    .wb_last_o    (wb_last_o)
  );

  // EX keeps its request valid while the second split phase is pending
  a_phase2_valid : assert property (
    @(posedge clk) disable iff (!rst_n) !first_op |-> ex_valid_i
  );

endmodule

//--- verilog/lsu_txn_ctrl.sv
////////////////////////////////////////////////////////////
// Load/store transaction control
// Counts outstanding bus transactions, queues their info for
// WB and drives the EX handshake, busy and interruptible
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_txn_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ex_valid_i,
  input  logic                   split_i,
  input  lsu_pkg::lsu_txn_info_t txn_info_i,
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  output logic                   bus_req_o,
  output logic                   ex_update_o,
  output logic                   ex_ready_o,
  output lsu_pkg::lsu_txn_info_t head_info_o,
  output logic                   busy_o,
  output logic                   interruptible_o
);

  import lsu_pkg::*;

  lsu_cnt_t      cnt_q;
  lsu_cnt_t      cnt_d;
  logic          accept;
  // Info queue, one entry per outstanding transaction
  lsu_txn_info_t info_q [LSU_DEPTH];
  logic          wr_ptr_q;
  logic          rd_ptr_q;
  // Request seen without a grant
  logic          wait_q;

  // Request only while there is room for another response
  assign bus_req_o   = ex_valid_i && (cnt_q < lsu_cnt_t'(LSU_DEPTH));
  assign accept      = bus_req_o && bus_gnt_i;
  assign ex_update_o = accept;

  // First half of a split keeps EX occupied
  assign ex_ready_o = !ex_valid_i || (accept && !split_i);

  ////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////

  always_comb begin
    cnt_d = cnt_q;
    case ({accept, bus_rvalid_i})
      2'b10:   cnt_d = cnt_q + 2'd1;
      2'b01:   cnt_d = cnt_q - 2'd1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Push on grant, pop on response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (accept) wr_ptr_q <= !wr_ptr_q;
      if (bus_rvalid_i) rd_ptr_q <= !rd_ptr_q;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      info_q[wr_ptr_q] <= txn_info_i;
    end
  end

  // Oldest outstanding transaction
  assign head_info_o = info_q[rd_ptr_q];

  ////////////////////////////////////////////////////////////
  // Status
  ////////////////////////////////////////////////////////////

  // Once a request has been on the bus it may not be withdrawn
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_q <= 1'b0;
    end else if (accept || !ex_valid_i) begin
      wait_q <= 1'b0;
    end else if (bus_req_o) begin
      wait_q <= 1'b1;
    end
  end

  assign busy_o          = bus_req_o || (cnt_q != '0);
  assign interruptible_o = !wait_q && (cnt_q == '0);

  a_no_orphan_resp : assert property (
    @(posedge clk) disable iff (!rst_n) bus_rvalid_i |-> (cnt_q != '0)
  );

  a_cnt_in_range : assert property (
    @(posedge clk) disable iff (!rst_n) cnt_q <= lsu_cnt_t'(LSU_DEPTH)
  );

endmodule
